//--- hw/board_pkg.sv
/*
  shared LFSR constants and the exit word layout
*/
`default_nettype none

package board_pkg;

  // seed and worker state width
  localparam int unsigned LFSR_WIDTH = 16;

  // galois feedback mask, taps 16 14 13 11
  localparam logic [LFSR_WIDTH-1:0] LFSR_TAPS = 16'hB400;

  localparam int unsigned EXIT_WIDTH = 32;

  // one lockup bit per worker
  localparam int unsigned MAX_WORKERS = 15;

  // exit word, read whole or by field
  typedef union packed {
    logic [EXIT_WIDTH-1:0] raw;
    struct packed {
      logic [LFSR_WIDTH-1:0]  signature;
      logic [MAX_WORKERS-1:0] lockup_mask;
      logic                   error;
    } fields;
  } exit_word_u;

endpackage

`default_nettype wire

//--- hw/board_status.sv
/*
  board reset polarity and two-flop reset synchronizer,
  reset LED and clock blink counter
*/
`timescale 1ns/1ps
`default_nettype none

module board_status #(
  parameter bit          RST_ACTIVE_LOW       = 1'b0,
  parameter int unsigned CLK_LED_COUNT_LENGTH = 27
) (
  input  wire  clk_gen,
  input  wire  rst_i,
  output logic rst_n_o,
  output logic rst_led_o,
  output logic clk_led_o
);

  logic                            rst_req_n;
  logic [1:0]                      rst_sync;
  logic [CLK_LED_COUNT_LENGTH-1:0] clk_count;

  // active low request from the board pin
  assign rst_req_n = RST_ACTIVE_LOW ? rst_i : ~rst_i;

  // assert at once, release after two edges
  always_ff @(posedge clk_gen or negedge rst_req_n) begin
    if (!rst_req_n) begin
      rst_sync <= 2'b00;
    end else begin
      rst_sync <= {rst_sync[0], 1'b1};
    end
  end

  assign rst_n_o = rst_sync[1];

  assign rst_led_o = rst_n_o;

  // free running blink counter
  always_ff @(posedge clk_gen or negedge rst_n_o) begin
    if (!rst_n_o) begin
      clk_count <= '0;
    end else begin
      clk_count <= clk_count + 1'b1;
    end
  end

  assign clk_led_o = clk_count[CLK_LED_COUNT_LENGTH-1];

endmodule

`default_nettype wire

//--- hw/seed_loader.sv
/*
  start edge detection, busy flag and per-worker seed fan-out
*/
`timescale 1ns/1ps
`default_nettype none

module seed_loader
  import board_pkg::*;
#(
  parameter int unsigned NUM_WORKERS = 4
) (
  input  wire                                  clk_gen,
  input  wire                                  rst_n,
  input  wire                                  start_i,
  input  wire  [LFSR_WIDTH-1:0]                seed_i,
  input  wire                                  done_all_i,
  output logic                                 load_o,
  output logic [NUM_WORKERS*LFSR_WIDTH-1:0]    seeds_o
);

  logic start_q;
  logic busy_q;
  logic accept;

  // rising edge of the start level, only when idle
  assign accept = start_i & ~start_q & ~busy_q;

  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      start_q <= 1'b0;
      busy_q  <= 1'b0;
      load_o  <= 1'b0;
    end else begin
      start_q <= start_i;
      load_o  <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (done_all_i && !load_o) begin
        // done bits of the previous run are still up during the load pulse
        busy_q <= 1'b0;
      end
    end
  end

  // worker k gets seed plus k
  always_ff @(posedge clk_gen) begin
    if (accept) begin
      for (int k = 0; k < NUM_WORKERS; k++) begin
        seeds_o[k*LFSR_WIDTH +: LFSR_WIDTH] <= seed_i + LFSR_WIDTH'(k);
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/lfsr_worker.sv
/*
  one galois LFSR worker, steps a fixed count after load and flags done
*/
`timescale 1ns/1ps
`default_nettype none

module lfsr_worker
  import board_pkg::*;
#(
  parameter int unsigned STEPS = 16
) (
  input  wire                   clk_gen,
  input  wire                   rst_n,
  input  wire                   load_i,
  input  wire  [LFSR_WIDTH-1:0] seed_i,
  output logic [LFSR_WIDTH-1:0] state_o,
  output logic                  done_o
);

  localparam int unsigned CNT_W = $clog2(STEPS + 1);

  logic [CNT_W-1:0] step_cnt;
  logic             stepping;

  assign stepping = (step_cnt != '0);

  // step counter and done flag
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      step_cnt <= '0;
      done_o   <= 1'b0;
    end else if (load_i) begin
      step_cnt <= CNT_W'(STEPS);
      done_o   <= 1'b0;
    end else if (stepping) begin
      step_cnt <= step_cnt - 1'b1;
      if (step_cnt == CNT_W'(1)) begin
        done_o <= 1'b1;
      end
    end
  end

  // shift right, fold taps in when a one drops out
  always_ff @(posedge clk_gen) begin
    if (load_i) begin
      state_o <= seed_i;
    end else if (stepping) begin
      if (state_o[0]) begin
        state_o <= (state_o >> 1) ^ LFSR_TAPS;
      end else begin
        state_o <= state_o >> 1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/exit_collector.sv
/*
  combines final worker states into the exit word and holds exit_valid_o
*/
`timescale 1ns/1ps
`default_nettype none

module exit_collector
  import board_pkg::*;
#(
  parameter int unsigned NUM_WORKERS = 4
) (
  input  wire                                clk_gen,
  input  wire                                rst_n,
  input  wire                                load_i,
  input  wire  [NUM_WORKERS-1:0]             done_i,
  input  wire  [NUM_WORKERS*LFSR_WIDTH-1:0]  states_i,
  output logic                               done_all_o,
  output logic [EXIT_WIDTH-1:0]              exit_value_o,
  output logic                               exit_valid_o
);

  exit_word_u word_d;
  exit_word_u word_q;

  assign done_all_o = &done_i;

  // signature, zero-state mask and error flag
  always_comb begin
    word_d.raw = '0;
    for (int k = 0; k < NUM_WORKERS; k++) begin
      word_d.fields.signature = word_d.fields.signature ^
                                states_i[k*LFSR_WIDTH +: LFSR_WIDTH];
      if (states_i[k*LFSR_WIDTH +: LFSR_WIDTH] == '0) begin
        word_d.fields.lockup_mask[k] = 1'b1;
      end
    end
    word_d.fields.error = |word_d.fields.lockup_mask;
  end

  // new load drops valid, result kept until then
  always_ff @(posedge clk_gen or negedge rst_n) begin
    if (!rst_n) begin
      word_q.raw   <= '0;
      exit_valid_o <= 1'b0;
    end else if (load_i) begin
      exit_valid_o <= 1'b0;
    end else if (done_all_o && !exit_valid_o) begin
      word_q       <= word_d;
      exit_valid_o <= 1'b1;
    end
  end

  assign exit_value_o = word_q.raw;

endmodule

`default_nettype wire

//--- hw/lfsr_system.sv
/*
  seed loader, array of LFSR workers and exit collector
*/
`timescale 1ns/1ps
`default_nettype none

module lfsr_system
  import board_pkg::*;
#(
  parameter int unsigned NUM_WORKERS = 4,
  parameter int unsigned STEPS       = 16
) (
  input  wire                   clk_gen,
  input  wire                   rst_n,
  input  wire                   start_i,
  input  wire  [LFSR_WIDTH-1:0] seed_i,
  output logic [EXIT_WIDTH-1:0] exit_value_o,
  output logic                  exit_valid_o
);

  logic                              load;
  logic                              done_all;
  logic [NUM_WORKERS*LFSR_WIDTH-1:0] seeds;
  logic [NUM_WORKERS*LFSR_WIDTH-1:0] states;
  logic [NUM_WORKERS-1:0]            done;

  seed_loader #(
    .NUM_WORKERS(NUM_WORKERS)
  ) seed_loader_inst (
    .clk_gen   (clk_gen),
    .rst_n     (rst_n),
    .start_i   (start_i),
    .seed_i    (seed_i),
    .done_all_i(done_all),
    .load_o    (load),
    .seeds_o   (seeds)
  );

  for (genvar k = 0; k < NUM_WORKERS; k++) begin : gen_worker
    lfsr_worker #(
      .STEPS(STEPS)
    ) lfsr_worker_inst (
      .clk_gen(clk_gen),
      .rst_n  (rst_n),
      .load_i (load),
      .seed_i (seeds[k*LFSR_WIDTH +: LFSR_WIDTH]),
      .state_o(states[k*LFSR_WIDTH +: LFSR_WIDTH]),
      .done_o (done[k])
    );
  end

  exit_collector #(
    .NUM_WORKERS(NUM_WORKERS)
  ) exit_collector_inst (
    .clk_gen     (clk_gen),
    .rst_n       (rst_n),
    .load_i      (load),
    .done_i      (done),
    .states_i    (states),
    .done_all_o  (done_all),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

endmodule

`default_nettype wire

//--- hw/fpga_board_wrapper.sv
/*
  board top, reset and LED handling around the LFSR system
*/
`timescale 1ns/1ps
`default_nettype none

module fpga_board_wrapper
  import board_pkg::*;
#(
  parameter int unsigned NUM_WORKERS          = 4,
  parameter int unsigned STEPS                = 16,
  parameter int unsigned CLK_LED_COUNT_LENGTH = 27,
  parameter bit          RST_ACTIVE_LOW       = 1'b0
) (
  input  wire                   clk_i,
  input  wire                   rst_i,
  input  wire                   start_i,
  input  wire  [LFSR_WIDTH-1:0] seed_i,
  output logic                  rst_led_o,
  output logic                  clk_led_o,
  output logic [EXIT_WIDTH-1:0] exit_value_o,
  output logic                  exit_valid_o
);

  // board clock used directly, no clock wizard
  wire clk_gen = clk_i;
  wire rst_n;

  board_status #(
    .RST_ACTIVE_LOW      (RST_ACTIVE_LOW),
    .CLK_LED_COUNT_LENGTH(CLK_LED_COUNT_LENGTH)
  ) board_status_inst (
    .clk_gen  (clk_gen),
    .rst_i    (rst_i),
    .rst_n_o  (rst_n),
    .rst_led_o(rst_led_o),
    .clk_led_o(clk_led_o)
  );

  lfsr_system #(
    .NUM_WORKERS(NUM_WORKERS),
    .STEPS      (STEPS)
  ) lfsr_system_inst (
    .clk_gen     (clk_gen),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .seed_i      (seed_i),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

endmodule

`default_nettype wire

//--- testbench/tb_fpga_board_wrapper.sv
/*
  testbench for the board wrapper, table of seeds with an LFSR reference
  model, reset and LED checks and a watchdog
*/
`timescale 1ns/1ps
`default_nettype none

module tb_fpga_board_wrapper;

  localparam int NUM_WORKERS     = 4;
  localparam int STEPS           = 16;
  localparam int LED_LEN         = 4;
  localparam int NUM_ROWS        = 8;
  localparam int WATCHDOG_CYCLES = NUM_ROWS * (STEPS + 10) + 100;
  // same feedback mask as the workers
  localparam logic [15:0] TAPS   = 16'hB400;

  logic        clk_gen = 1'b0;
  logic        rst_i;
  logic        start_i;
  logic [15:0] seed_i;
  wire         rst_led_o;
  wire         clk_led_o;
  wire  [31:0] exit_value_o;
  wire         exit_valid_o;

  logic [15:0] seed_tab [NUM_ROWS];
  bit          busy_tab [NUM_ROWS];
  integer      seed_var    = 32'h91d4c46b;
  int          error_count = 0;
  int          test_count  = 0;
  int          pass_count  = 0;

  fpga_board_wrapper #(
    .NUM_WORKERS         (NUM_WORKERS),
    .STEPS               (STEPS),
    .CLK_LED_COUNT_LENGTH(LED_LEN),
    .RST_ACTIVE_LOW      (1'b0)
  ) fpga_board_wrapper_inst (
    .clk_i       (clk_gen),
    .rst_i       (rst_i),
    .start_i     (start_i),
    .seed_i      (seed_i),
    .rst_led_o   (rst_led_o),
    .clk_led_o   (clk_led_o),
    .exit_value_o(exit_value_o),
    .exit_valid_o(exit_valid_o)
  );

  always #20 clk_gen = ~clk_gen;

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_gen);
    $display("watchdog expired at %0t, the DUT stopped responding", $time);
    $display("Simulation failed");
    $finish;
  end

  // exit word layout is signature, lockup mask, error bit
  task automatic expected_exit_word(input logic [15:0] seed, output logic [31:0] word);
    logic [15:0] state;
    logic [15:0] signature;
    logic [14:0] mask;
    signature = '0;
    mask = '0;
    for (int k = 0; k < NUM_WORKERS; k++) begin
      state = seed + 16'(k);
      for (int n = 0; n < STEPS; n++) begin
        if (state[0]) begin
          state = (state >> 1) ^ TAPS;
        end else begin
          state = state >> 1;
        end
      end
      signature = signature ^ state;
      if (state == 16'h0000) begin
        mask[k] = 1'b1;
      end
    end
    word = {signature, mask, |mask};
  endtask

  task automatic compare_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    if (actual !== expected) begin
      $display("Fail at %0t: %s expected %h got %h", $time, name, expected, actual);
      error_count++;
    end
  endtask

  task automatic report_problem(input string msg);
    $display("error at %0t: %s", $time, msg);
    error_count++;
  endtask

  task automatic finish_test(input string label, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
      pass_count++;
      $display("%s: ok", label);
    end else begin
      $display("%s: FAILED", label);
    end
  endtask

  task automatic check_reset_release();
    int errors_before;
    errors_before = error_count;
    repeat (5) @(posedge clk_gen);
    rst_i <= 1'b0;
    @(negedge clk_gen);
    compare_value("rst_led_o", 32'(1'b0), 32'(rst_led_o));
    // synchronizer needs two edges
    repeat (2) @(posedge clk_gen);
    @(negedge clk_gen);
    compare_value("rst_led_o", 32'(1'b1), 32'(rst_led_o));
    compare_value("exit_valid_o", 32'(1'b0), 32'(exit_valid_o));
    compare_value("exit_value_o", 32'h0, exit_value_o);
    finish_test("reset release", errors_before);
  endtask

  task automatic check_clk_led();
    int   errors_before;
    int   cycles;
    int   changes;
    logic prev;
    errors_before = error_count;
    // counting starts right at reset release
    prev = clk_led_o;
    cycles = 0;
    changes = 0;
    repeat (30) begin
      @(negedge clk_gen);
      cycles++;
      if (clk_led_o !== prev) begin
        compare_value("clk_led_o period", 32'(1 << (LED_LEN - 1)), 32'(cycles));
        changes++;
        cycles = 0;
        prev = clk_led_o;
      end
    end
    if (changes < 2) begin
      report_problem("clk_led_o did not toggle often enough");
    end
    finish_test("clock led blink", errors_before);
  endtask

  task automatic run_row(input int row);
    logic [15:0] seed;
    logic [31:0] expected;
    logic [31:0] held;
    int          cycles;
    int          errors_before;
    bit          seen;
    seed = seed_tab[row];
    errors_before = error_count;
    expected_exit_word(seed, expected);
    @(posedge clk_gen);
    seed_i  <= seed;
    start_i <= 1'b1;
    cycles = 0;
    seen = 1'b0;
    // cycle 1 is the edge that accepts the start
    while (!seen && cycles < STEPS + 6) begin
      @(posedge clk_gen);
      cycles++;
      if (busy_tab[row]) begin
        if (cycles == 4) begin
          start_i <= 1'b0;
          seed_i  <= seed ^ 16'h5a5a;
        end
        if (cycles == 7) begin
          start_i <= 1'b1;
        end
        if (cycles == 9) begin
          start_i <= 1'b0;
        end
      end
      @(negedge clk_gen);
      if (cycles == 2 && exit_valid_o !== 1'b0) begin
        report_problem("exit_valid_o did not drop after a new start");
      end
      if (cycles >= 2 && exit_valid_o === 1'b1) begin
        seen = 1'b1;
      end
    end
    if (!seen) begin
      report_problem("exit_valid_o never rose");
    end else begin
      compare_value("exit_valid_o latency", 32'(STEPS + 2), 32'(cycles - 1));
      compare_value("exit_value_o", expected, exit_value_o);
      // a zero seed never leaves zero
      for (int k = 0; k < NUM_WORKERS; k++) begin
        if (16'(seed + 16'(k)) == 16'h0000) begin
          compare_value("exit_value_o lockup bit", 32'(1'b1), 32'(exit_value_o[k + 1]));
          compare_value("exit_value_o error bit", 32'(1'b1), 32'(exit_value_o[0]));
        end
      end
      held = exit_value_o;
      repeat (3) begin
        @(negedge clk_gen);
        compare_value("exit_valid_o", 32'(1'b1), 32'(exit_valid_o));
        compare_value("exit_value_o", held, exit_value_o);
      end
    end
    @(posedge clk_gen);
    start_i <= 1'b0;
    @(posedge clk_gen);
    finish_test($sformatf("row %0d seed %h%s", row, seed,
                          busy_tab[row] ? " with start while busy" : ""), errors_before);
  endtask

  initial begin
    rst_i   = 1'b1;
    start_i = 1'b0;
    seed_i  = '0;
    seed_tab[0] = 16'hace1;
    busy_tab[0] = 1'b0;
    seed_tab[1] = 16'h0000;
    busy_tab[1] = 1'b0;
    seed_tab[2] = 16'hfffd;
    busy_tab[2] = 1'b0;
    seed_tab[3] = 16'h1234;
    busy_tab[3] = 1'b1;
    seed_tab[4] = 16'h8001;
    busy_tab[4] = 1'b0;
    seed_tab[5] = 16'hbeef;
    busy_tab[5] = 1'b1;
    seed_tab[6] = 16'($random(seed_var));
    busy_tab[6] = 1'b0;
    seed_tab[7] = 16'($random(seed_var));
    busy_tab[7] = 1'b1;

    check_reset_release();
    check_clk_led();
    for (int row = 0; row < NUM_ROWS; row++) begin
      run_row(row);
    end

    $display("tests run %0d, passed %0d, failed %0d", test_count, pass_count,
             test_count - pass_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
hw/board_pkg.sv
hw/board_status.sv
hw/seed_loader.sv
hw/lfsr_worker.sv
hw/exit_collector.sv
hw/lfsr_system.sv
hw/fpga_board_wrapper.sv
testbench/tb_fpga_board_wrapper.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_fpga_board_wrapper \
  -f list.f -o sim_tb || exit 1

result=$(./obj_dir/sim_tb)
printf '%s\n' "$result"

printf '%s\n' "$result" | grep -q "Simulation passed" && exit 0 || exit 1
